// ==== source/bus_pkg.sv ====
// word, byte-enable and block types shared by the processor and memory ports
// reference these by scoped name, e.g. bus_pkg::word_t
package bus_pkg;

    // processor side
    localparam int WORD_W = 32;
    typedef logic [WORD_W-1:0] word_t;

    localparam int BYTES_PER_WORD = 4;
    typedef logic [BYTES_PER_WORD-1:0] byte_en_t;    // one bit per byte lane

    // memory side moves whole blocks
    localparam int BLOCK_WORDS = 2;
    typedef word_t [BLOCK_WORDS-1:0] block_t;        // word 0 in the low bits

endpackage

// ==== source/cache_pkg.sv ====
// cache geometry and the address view used for indexing
// field widths here must add up to bus_pkg::WORD_W
package cache_pkg;

    localparam int N_SETS = 64;                      // direct mapped, one line per set
    localparam int SET_W = 6;
    localparam int BLOCK_OFS_W = 1;                  // selects word within block
    localparam int BYTE_OFS_W = 2;

    // whatever is left over is tag
    localparam int TAG_W = bus_pkg::WORD_W - SET_W - BLOCK_OFS_W - BYTE_OFS_W;

    // one address, two views
    //   word  flat value, for memory addresses and compares
    //   f     split into tag / set / word / byte for indexing
    typedef union packed {
        bus_pkg::word_t word;
        struct packed {
            logic [TAG_W-1:0]       tag;
            logic [SET_W-1:0]       set;
            logic [BLOCK_OFS_W-1:0] blk;
            logic [BYTE_OFS_W-1:0]  byte_ofs;      // ignored, word accesses only
        } f;
    } cache_addr_u;

endpackage

// ==== source/cache_line_store.sv ====
// tag, valid, dirty and data arrays of the cache, one line per set
// reads are combinational, both write ports land on the rising clock edge
`timescale 1ns/1ps

module cache_line_store (
    input  logic                              CLK,
    input  logic                              nRST,
    // read select
    input  logic [cache_pkg::SET_W-1:0]       rd_set,
    input  logic                              sweep_active,
    input  logic [cache_pkg::SET_W-1:0]       sweep_set,
    // word write, byte masked
    input  logic                              wr_en,
    input  logic [cache_pkg::SET_W-1:0]       wr_set,
    input  logic [cache_pkg::BLOCK_OFS_W-1:0] wr_word,
    input  bus_pkg::word_t                    wr_data,
    input  bus_pkg::word_t                    wr_mask,
    // whole block write
    input  logic                              fill_en,
    input  logic [cache_pkg::SET_W-1:0]       fill_set,
    input  logic [cache_pkg::TAG_W-1:0]       fill_tag,
    input  bus_pkg::block_t                   fill_data,
    input  logic                              fill_valid,
    // read data
    output logic [cache_pkg::TAG_W-1:0]       rd_tag,
    output logic                              rd_valid,
    output logic                              rd_dirty,
    output bus_pkg::block_t                   rd_data
);

    logic [cache_pkg::TAG_W-1:0] tag_q  [cache_pkg::N_SETS];
    bus_pkg::block_t             data_q [cache_pkg::N_SETS];
    logic [cache_pkg::N_SETS-1:0] valid_q;
    logic [cache_pkg::N_SETS-1:0] dirty_q;

    logic [cache_pkg::SET_W-1:0] rd_idx;
    bus_pkg::word_t              old_word;

    // sweep and flush walk the sets themselves
    assign rd_idx = sweep_active ? sweep_set : rd_set;

    assign rd_tag   = tag_q[rd_idx];
    assign rd_valid = valid_q[rd_idx];
    assign rd_dirty = dirty_q[rd_idx];
    assign rd_data  = data_q[rd_idx];

    assign old_word = data_q[wr_set][wr_word];

    // status bits
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (wr_en) begin
                dirty_q[wr_set] <= 1'b1;
            end
            if (fill_en) begin
                valid_q[fill_set] <= fill_valid;
                dirty_q[fill_set] <= 1'b0;   // fresh block or invalidated
            end
        end
    end

    // tags and data
    always_ff @(posedge CLK) begin
        if (wr_en) begin
            data_q[wr_set][wr_word] <= (old_word & ~wr_mask) | (wr_data & wr_mask);
        end
        if (fill_en) begin
            tag_q[fill_set]  <= fill_tag;
            data_q[fill_set] <= fill_data;
        end
    end

endmodule

// ==== source/cache_lookup.sv ====
// front end of the cache: takes a processor request, compares tags and
// answers hits; misses are handed to the controller and retried when it idles
`timescale 1ns/1ps

module cache_lookup (
    input  logic                              CLK,
    input  logic                              nRST,
    // processor port
    input  logic                              req_valid,
    input  logic                              req_write,
    input  bus_pkg::word_t                    req_addr,
    input  bus_pkg::word_t                    req_wdata,
    input  bus_pkg::byte_en_t                 req_byte_en,
    output logic                              req_ready,
    output bus_pkg::word_t                    req_rdata,
    // controller status
    input  logic                              ctrl_idle,
    // store read
    output logic [cache_pkg::SET_W-1:0]       rd_set,
    input  logic [cache_pkg::TAG_W-1:0]       rd_tag,
    input  logic                              rd_valid,
    input  logic                              rd_dirty,
    input  bus_pkg::block_t                   rd_data,
    // store word write
    output logic                              wr_en,
    output logic [cache_pkg::SET_W-1:0]       wr_set,
    output logic [cache_pkg::BLOCK_OFS_W-1:0] wr_word,
    output bus_pkg::word_t                    wr_data,
    output bus_pkg::word_t                    wr_mask,
    // to controller
    output logic                              miss,
    output bus_pkg::word_t                    miss_addr,
    output logic                              victim_dirty
);

    logic                   busy_q;     // request captured, not yet answered
    cache_pkg::cache_addr_u addr_q;
    logic                   write_q;
    bus_pkg::word_t         wdata_q;
    bus_pkg::byte_en_t      be_q;

    logic                   capture;
    logic                   hit;

    // only take a new request while the controller leaves the store alone
    assign capture = req_valid & ~busy_q & ctrl_idle;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            busy_q <= 1'b0;
        end else if (capture) begin
            busy_q <= 1'b1;
        end else if (req_ready) begin
            busy_q <= 1'b0;
        end
    end

    // request payload, held while a miss is serviced
    always_ff @(posedge CLK) begin
        if (capture) begin
            addr_q.word <= req_addr;
            write_q     <= req_write;
            wdata_q     <= req_wdata;
            be_q        <= req_byte_en;
        end
    end

    assign rd_set = addr_q.f.set;
    assign hit    = rd_valid & (rd_tag == addr_q.f.tag);

    // answer in the cycle after capture, or after the refill
    assign req_ready = busy_q & ctrl_idle & hit;
    assign req_rdata = rd_data[addr_q.f.blk];

    assign miss         = busy_q & ctrl_idle & ~hit;
    assign miss_addr    = addr_q.word;
    assign victim_dirty = rd_valid & rd_dirty;   // line about to be replaced

    // write hit goes straight into the store, which also sets dirty
    assign wr_en   = req_ready & write_q;
    assign wr_set  = addr_q.f.set;
    assign wr_word = addr_q.f.blk;
    assign wr_data = wdata_q;

    // byte enables -> bit mask
    always_comb begin
        wr_mask = '0;
        for (int i = 0; i < bus_pkg::BYTES_PER_WORD; i++) begin
            wr_mask[8*i +: 8] = {8{be_q[i]}};
        end
    end

endmodule

// ==== source/cache_miss_ctrl.sv ====
// back end of the cache: post-reset invalidation sweep, victim writeback,
// block fetch and flush, all over the block-wide memory port
`timescale 1ns/1ps

module cache_miss_ctrl (
    input  logic                        CLK,
    input  logic                        nRST,
    // from lookup
    input  logic                        miss,
    input  bus_pkg::word_t              miss_addr,
    input  logic                        victim_dirty,
    // store read
    input  logic [cache_pkg::TAG_W-1:0] rd_tag,
    input  logic                        rd_valid,
    input  logic                        rd_dirty,
    input  bus_pkg::block_t             rd_data,
    // flush request
    input  logic                        flush,
    output logic                        flush_done,
    // memory port
    input  logic                        mem_ready,
    input  bus_pkg::block_t             mem_rdata,
    output logic                        mem_valid,
    output logic                        mem_write,
    output bus_pkg::word_t              mem_addr,
    output bus_pkg::block_t             mem_wdata,
    // store control
    output logic                        ctrl_idle,
    output logic                        sweep_active,
    output logic [cache_pkg::SET_W-1:0] sweep_set,
    output logic                        fill_en,
    output logic [cache_pkg::SET_W-1:0] fill_set,
    output logic [cache_pkg::TAG_W-1:0] fill_tag,
    output bus_pkg::block_t             fill_data,
    output logic                        fill_valid
);

    localparam logic [2:0] ST_SWEEP = 3'd0;
    localparam logic [2:0] ST_IDLE  = 3'd1;
    localparam logic [2:0] ST_WB    = 3'd2;
    localparam logic [2:0] ST_FETCH = 3'd3;
    localparam logic [2:0] ST_FLUSH = 3'd4;

    logic [2:0]                  state_q, state_d;
    logic [cache_pkg::SET_W-1:0] set_q, set_d;      // sweep / flush position
    logic                        flush_pend_q;
    cache_pkg::cache_addr_u      miss_q;            // block being fetched
    cache_pkg::cache_addr_u      blk_addr;
    logic                        last_set;
    logic                        start_flush;

    assign last_set    = int'(set_q) == cache_pkg::N_SETS - 1;
    assign start_flush = (state_q == ST_IDLE) & ~miss & (flush | flush_pend_q);

    assign ctrl_idle    = state_q == ST_IDLE;
    assign sweep_active = (state_q == ST_SWEEP) | (state_q == ST_FLUSH);
    assign sweep_set    = set_q;

    always_comb begin
        state_d    = state_q;
        set_d      = set_q;
        blk_addr   = '0;
        mem_valid  = 1'b0;
        mem_write  = 1'b0;
        mem_addr   = '0;
        mem_wdata  = rd_data;
        fill_en    = 1'b0;
        fill_set   = set_q;
        fill_tag   = '0;
        fill_data  = mem_rdata;
        fill_valid = 1'b0;
        flush_done = 1'b0;

        case (state_q)
            ST_SWEEP: begin
                fill_en = 1'b1;          // invalidate one set per cycle
                set_d   = set_q + 1'b1;
                if (last_set) begin
                    state_d = ST_IDLE;
                end
            end
            ST_IDLE: begin
                if (miss) begin
                    state_d = victim_dirty ? ST_WB : ST_FETCH;
                end else if (start_flush) begin
                    state_d = ST_FLUSH;
                    set_d   = '0;
                end
            end
            ST_WB: begin
                // victim lives in the same set, stored tag gives its address
                blk_addr.f.tag = rd_tag;
                blk_addr.f.set = miss_q.f.set;
                mem_valid      = 1'b1;
                mem_write      = 1'b1;
                mem_addr       = blk_addr.word;
                if (mem_ready) begin
                    state_d = ST_FETCH;
                end
            end
            ST_FETCH: begin
                blk_addr.f.tag = miss_q.f.tag;
                blk_addr.f.set = miss_q.f.set;
                mem_valid      = 1'b1;
                mem_addr       = blk_addr.word;
                fill_set       = miss_q.f.set;
                fill_tag       = miss_q.f.tag;
                fill_valid     = 1'b1;
                if (mem_ready) begin
                    fill_en = 1'b1;
                    state_d = ST_IDLE;   // lookup retries and now hits
                end
            end
            ST_FLUSH: begin
                blk_addr.f.tag = rd_tag;
                blk_addr.f.set = set_q;
                if (rd_valid && rd_dirty) begin
                    mem_valid = 1'b1;
                    mem_write = 1'b1;
                    mem_addr  = blk_addr.word;
                end
                // move on once the set is clean or written back
                if (!(rd_valid && rd_dirty) || mem_ready) begin
                    fill_en = 1'b1;
                    set_d   = set_q + 1'b1;
                    if (last_set) begin
                        flush_done = 1'b1;
                        state_d    = ST_IDLE;
                    end
                end
            end
            default: begin
                state_d = ST_SWEEP;
                set_d   = '0;
            end
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state_q      <= ST_SWEEP;
            set_q        <= '0;
            flush_pend_q <= 1'b0;
        end else begin
            state_q      <= state_d;
            set_q        <= set_d;
            flush_pend_q <= (flush_pend_q | flush) & ~start_flush;
        end
    end

    // miss address only changes when a miss is taken
    always_ff @(posedge CLK) begin
        if (state_q == ST_IDLE && miss) begin
            miss_q.word <= miss_addr;
        end
    end

endmodule

// ==== source/l1_cache.sv ====
// direct-mapped write-back L1 data cache, processor port on one side and
// block-wide memory port on the other; pulse flush to write back everything
`timescale 1ns/1ps

module l1_cache (
    input  logic                 CLK,
    input  logic                 nRST,
    // processor port
    input  logic                 req_valid,
    input  logic                 req_write,
    input  bus_pkg::word_t       req_addr,
    input  bus_pkg::word_t       req_wdata,
    input  bus_pkg::byte_en_t    req_byte_en,
    output logic                 req_ready,
    output bus_pkg::word_t       req_rdata,
    // flush control
    input  logic                 flush,
    output logic                 flush_done,
    // memory port
    output logic                 mem_valid,
    output logic                 mem_write,
    output bus_pkg::word_t       mem_addr,
    output bus_pkg::block_t      mem_wdata,
    input  logic                 mem_ready,
    input  bus_pkg::block_t      mem_rdata
);

    // store read side
    logic [cache_pkg::SET_W-1:0]       rd_set;
    logic [cache_pkg::TAG_W-1:0]       rd_tag;
    logic                              rd_valid;
    logic                              rd_dirty;
    bus_pkg::block_t                   rd_data;

    // word write from lookup
    logic                              wr_en;
    logic [cache_pkg::SET_W-1:0]       wr_set;
    logic [cache_pkg::BLOCK_OFS_W-1:0] wr_word;
    bus_pkg::word_t                    wr_data;
    bus_pkg::word_t                    wr_mask;

    // block write from controller
    logic                              fill_en;
    logic [cache_pkg::SET_W-1:0]       fill_set;
    logic [cache_pkg::TAG_W-1:0]       fill_tag;
    bus_pkg::block_t                   fill_data;
    logic                              fill_valid;
    logic                              sweep_active;
    logic [cache_pkg::SET_W-1:0]       sweep_set;

    // lookup <-> controller
    logic                              miss;
    bus_pkg::word_t                    miss_addr;
    logic                              victim_dirty;
    logic                              ctrl_idle;

    cache_lookup u_lookup (
        .CLK, .nRST,
        .req_valid, .req_write, .req_addr, .req_wdata, .req_byte_en,
        .ctrl_idle, .rd_tag, .rd_valid, .rd_dirty, .rd_data,
        .req_ready, .req_rdata, .rd_set,
        .wr_en, .wr_set, .wr_word, .wr_data, .wr_mask,
        .miss, .miss_addr, .victim_dirty
    );

    cache_line_store u_store (
        .CLK, .nRST,
        .rd_set, .sweep_active, .sweep_set,
        .wr_en, .wr_set, .wr_word, .wr_data, .wr_mask,
        .fill_en, .fill_set, .fill_tag, .fill_data, .fill_valid,
        .rd_tag, .rd_valid, .rd_dirty, .rd_data
    );

    cache_miss_ctrl u_ctrl (
        .CLK, .nRST,
        .miss, .miss_addr, .victim_dirty,
        .rd_tag, .rd_valid, .rd_dirty, .rd_data,
        .flush, .mem_ready, .mem_rdata,
        .ctrl_idle, .sweep_active, .sweep_set,
        .fill_en, .fill_set, .fill_tag, .fill_data, .fill_valid,
        .mem_valid, .mem_write, .mem_addr, .mem_wdata, .flush_done
    );

endmodule

// ==== verif/l1_cache_tb.sv ====
// testbench for the L1 cache that plays the requests in the testdata file
// against a 4 KB block memory model with random ready delay
// run from the project root so the data file is found
`timescale 1ns/1ps

module l1_cache_tb;

    localparam int MAX_REQ   = 64;
    localparam int MEM_WORDS = 1024;           // 4 KB image

    logic              CLK;
    logic              nRST;
    logic              req_valid;
    logic              req_write;
    bus_pkg::word_t    req_addr;
    bus_pkg::word_t    req_wdata;
    bus_pkg::byte_en_t req_byte_en;
    logic              req_ready;
    bus_pkg::word_t    req_rdata;
    logic              flush;
    logic              flush_done;
    logic              mem_valid;
    logic              mem_write;
    bus_pkg::word_t    mem_addr;
    bus_pkg::block_t   mem_wdata;
    logic              mem_ready;
    bus_pkg::block_t   mem_rdata;

    bus_pkg::word_t    image  [MEM_WORDS];     // memory model contents
    bus_pkg::word_t    shadow [MEM_WORDS];     // initial pattern plus every write
    bus_pkg::word_t    vec    [MAX_REQ*5];     // op, addr, wdata, be, expected

    integer            seed         = 32'h0ab3f5e8;
    int                errors       = 0;
    int                proto_errors = 0;       // handshake rule broken
    int                wb_count     = 0;       // memory writes seen
    int                cycles       = 0;
    int                limit        = 1000000; // set from the request count
    int                n_req        = 0;
    int unsigned       wait_cnt     = 0;
    logic [9:0]        word_idx;

    l1_cache UUT (
        .CLK, .nRST,
        .req_valid, .req_write, .req_addr, .req_wdata, .req_byte_en,
        .req_ready, .req_rdata,
        .flush, .flush_done,
        .mem_valid, .mem_write, .mem_addr, .mem_wdata, .mem_ready, .mem_rdata
    );

    always #20 CLK = ~CLK;

    function automatic bus_pkg::word_t initial_word(input bus_pkg::word_t addr);
        return addr ^ 32'h5a5a0000;
    endfunction

    // byte lanes with be set take the new data
    function automatic bus_pkg::word_t merge_bytes(input bus_pkg::word_t old,
                                                   input bus_pkg::word_t wdata,
                                                   input bus_pkg::byte_en_t be);
        bus_pkg::word_t res;
        res = old;
        for (int i = 0; i < bus_pkg::BYTES_PER_WORD; i++) begin
            if (be[i]) begin
                res[8*i +: 8] = wdata[8*i +: 8];
            end
        end
        return res;
    endfunction

    task automatic check_word(input string name, input bus_pkg::word_t got,
                              input bus_pkg::word_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %08h expected %08h", name, got, exp);
        end
    endtask

    task automatic check_block(input string name, input bus_pkg::block_t got,
                               input bus_pkg::block_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %016h expected %016h", name, got, exp);
        end
    endtask

    // memory model moves one block per transfer
    assign word_idx = {mem_addr[11:3], 1'b0};

    always @(posedge CLK) begin
        if (mem_valid && mem_ready) begin     // transfer completes at this edge
            if (mem_write) begin
                check_block("mem_wdata", mem_wdata,
                            {shadow[word_idx | 10'd1], shadow[word_idx]});
                image[word_idx]         <= mem_wdata[0];
                image[word_idx | 10'd1] <= mem_wdata[1];
                wb_count                <= wb_count + 1;
            end
            mem_ready <= 1'b0;
            wait_cnt  <= $unsigned($random(seed)) % 4;
        end else if (mem_valid) begin
            if (wait_cnt == 0) begin
                mem_ready <= 1'b1;
                mem_rdata <= {image[word_idx | 10'd1], image[word_idx]};
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end
    end

    // a request may only finish while the memory port is quiet
    always @(negedge CLK) begin
        if (nRST && req_ready && mem_valid) begin
            proto_errors++;
            $display("request answered while a memory transfer was still pending at %0t",
                     $time);
        end
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout: the run was still going after %0d cycles", limit);
            $display("Something failed");
            $finish;
        end
    end

    // hold the request until req_ready shows at a falling edge
    task automatic run_request(input logic is_write, input bus_pkg::word_t addr,
                               input bus_pkg::word_t wdata, input bus_pkg::byte_en_t be,
                               output bus_pkg::word_t rdata);
        @(posedge CLK);
        req_valid   <= 1'b1;
        req_write   <= is_write;
        req_addr    <= addr;
        req_wdata   <= wdata;
        req_byte_en <= be;
        @(negedge CLK);
        while (!req_ready) begin
            @(negedge CLK);
        end
        rdata = req_rdata;
        @(posedge CLK);
        req_valid <= 1'b0;
    endtask

    task automatic flush_and_compare();
        @(posedge CLK);
        flush <= 1'b1;
        @(posedge CLK);
        flush <= 1'b0;
        @(negedge CLK);
        while (!flush_done) begin
            @(negedge CLK);
        end
        @(negedge CLK);                       // last writeback now in the image
        for (int b = 0; b < MEM_WORDS/2; b++) begin
            check_block($sformatf("image[%03h]", b*8), {image[2*b+1], image[2*b]},
                        {shadow[2*b+1], shadow[2*b]});
        end
    endtask

    initial begin
        bus_pkg::word_t    op;
        bus_pkg::word_t    addr;
        bus_pkg::word_t    wdata;
        bus_pkg::byte_en_t be;
        bus_pkg::word_t    exp;
        bus_pkg::word_t    rdata;
        logic [9:0]        w;

        CLK         = 1'b0;
        nRST        = 1'b0;
        req_valid   = 1'b0;
        req_write   = 1'b0;
        req_addr    = '0;
        req_wdata   = '0;
        req_byte_en = '0;
        flush       = 1'b0;
        mem_ready   = 1'b0;
        mem_rdata   = '0;

        for (int i = 0; i < MEM_WORDS; i++) begin
            image[i]  = initial_word(bus_pkg::word_t'(4*i));
            shadow[i] = initial_word(bus_pkg::word_t'(4*i));
        end
        for (int i = 0; i < MAX_REQ*5; i++) begin
            vec[i] = 32'hf;                   // reads as end of list
        end
        $readmemh("verif/l1_cache_testdata.txt", vec);
        while (n_req < MAX_REQ && vec[5*n_req] <= 2) begin
            n_req++;
        end
        limit = 200 * n_req + 200;            // extra covers reset and the sweep

        repeat (5) @(posedge CLK);
        nRST <= 1'b1;

        for (int i = 0; i < n_req; i++) begin
            op    = vec[5*i];
            addr  = vec[5*i+1];
            wdata = vec[5*i+2];
            be    = vec[5*i+3][3:0];
            exp   = vec[5*i+4];
            w     = addr[11:2];
            case (op)
                0: begin
                    run_request(1'b0, addr, wdata, be, rdata);
                    check_word("req_rdata", rdata, exp);
                end
                1: begin
                    run_request(1'b1, addr, wdata, be, rdata);
                    shadow[w] = merge_bytes(shadow[w], wdata, be);
                end
                default: flush_and_compare();
            endcase
        end

        if (n_req == 0) begin
            errors++;
            $display("no requests were found in the test data file");
        end
        if (wb_count == 0) begin
            errors++;
            $display("no dirty block was ever written back to memory");
        end
        $display("%0d compare errors, %0d protocol errors after %0d requests",
                 errors, proto_errors, n_req);
        if (errors == 0 && proto_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
source/bus_pkg.sv
source/cache_pkg.sv
source/cache_line_store.sv
source/cache_lookup.sv
source/cache_miss_ctrl.sv
source/l1_cache.sv
verif/l1_cache_tb.sv

// ==== Makefile ====
# Verilator build and run of the L1 cache testbench, run from the project root

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
TOP       := l1_cache_tb
FILELIST  := sources.f
BUILD     := obj_dir
LOG       := sim.log
PASS_MSG  := Everything OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== verif/l1_cache_testdata.txt ====
// columns in hex: op (0 read, 1 write, 2 flush), address, write data, byte enables,
// expected read data; untouched memory holds address ^ 5a5a0000
0 00000100 00000000 0 5a5a0100
0 00000104 00000000 0 5a5a0104
1 00000100 11223344 3 00000000
0 00000100 00000000 0 5a5a3344
1 00000204 aabbccdd c 00000000
0 00000004 00000000 0 5a5a0004
0 00000204 00000000 0 aabb0204
1 00000300 deadbeef f 00000000
0 00000104 00000000 0 5a5a0104
0 00000100 00000000 0 5a5a3344
1 000007f8 01020304 9 00000000
1 00000ffc 55667788 6 00000000
1 00000040 0badf00d f 00000000
1 00000104 12345678 2 00000000
2 00000000 00000000 0 00000000
0 00000040 00000000 0 0badf00d
0 00000ffc 00000000 0 5a6677fc
0 000007f8 00000000 0 015a0704
0 00000104 00000000 0 5a5a5604
0 00000300 00000000 0 deadbeef
0 00000204 00000000 0 aabb0204
0 00000a08 00000000 0 5a5a0a08
1 00000a08 00ff00ff 5 00000000
0 00000a08 00000000 0 5aff0aff
2 00000000 00000000 0 00000000
0 00000000 00000000 0 5a5a0000
f 00000000 00000000 0 00000000
